// ==== hdl/snd_board.sv ====
/* Sound section top level. The CPU bus arrives as one-clock strobes.
   board_kind, fxlevel and the enables must stay static while running. */
`timescale 1ns/1ps
`default_nettype none

module snd_board (
    input  wire                  clk,
    input  wire                  rst,
    input  snd_pkg::cpu_bus_t    bus,
    input  wire                  sample_cen,
    input  snd_pkg::board_kind_t board_kind,
    input  wire [1:0]            fxlevel,
    input  wire                  enable_tone,
    input  wire                  enable_pcm,
    input  snd_pkg::cpu_data_t   rom_data,
    output snd_pkg::rom_addr_t   rom_addr,
    output logic                 rom_cs,
    output snd_pkg::cpu_data_t   cpu_din,
    output logic                 din_valid,
    output snd_pkg::sample_t     snd,
    output logic                 sample,
    output logic                 peak
);

    snd_pkg::voice_wr_t voice_wr;
    snd_pkg::sample_t   tone, pcm;
    logic               pcm_rst, pcm_busy_n;

    snd_bus_decode i_decode (
        .clk        (clk),
        .rst        (rst),
        .bus        (bus),
        .board_kind (board_kind),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .cpu_din    (cpu_din),
        .din_valid  (din_valid),
        .voice_wr   (voice_wr),
        .pcm_rst    (pcm_rst),
        .pcm_busy_n (pcm_busy_n)
    );

    snd_tone_voice i_tone (
        .clk        (clk),
        .rst        (rst),
        .sample_cen (sample_cen),
        .voice_wr   (voice_wr),
        .tone       (tone)
    );

    snd_pcm_voice i_pcm (
        .clk        (clk),
        .rst        (rst),
        .pcm_rst    (pcm_rst),
        .sample_cen (sample_cen),
        .voice_wr   (voice_wr),
        .busy_n     (pcm_busy_n),
        .pcm        (pcm)
    );

    snd_mixer i_mixer (
        .clk         (clk),
        .rst         (rst),
        .sample_cen  (sample_cen),
        .tone        (tone),
        .pcm         (pcm),
        .fxlevel     (fxlevel),
        .enable_tone (enable_tone),
        .enable_pcm  (enable_pcm),
        .snd         (snd),
        .sample      (sample),
        .peak        (peak)
    );

endmodule

`default_nettype wire

// ==== hdl/snd_bus_decode.sv ====
/* Sound CPU bus decoder. The ROM must answer in the cycle rom_cs is high.
   Read data is returned one clock after the read strobe.
   I/O ports decode on address bits 7:6 only; port 3 and E000-F7FF read FF. */
`timescale 1ns/1ps
`default_nettype none

`include "snd_defs.svh"

module snd_bus_decode (
    input  wire                 clk,
    input  wire                 rst,
    input  snd_pkg::cpu_bus_t   bus,
    input  snd_pkg::board_kind_t board_kind,
    output snd_pkg::rom_addr_t  rom_addr,
    output logic                rom_cs,
    input  snd_pkg::cpu_data_t  rom_data,
    output snd_pkg::cpu_data_t  cpu_din,
    output logic                din_valid,
    output snd_pkg::voice_wr_t  voice_wr,
    output logic                pcm_rst,
    input  wire                 pcm_busy_n
);

    snd_pkg::bank_t     bank;
    snd_pkg::rom_addr_t banked;
    snd_pkg::cpu_data_t ram [0:2047];
    logic [1:0]         onehot_idx;
    logic               fix_cs, bank_cs, ram_cs;
    logic               tone_port, ctl_port, pcm_port;
    logic               rd_stb;

    // Memory windows
    assign fix_cs  = bus.mreq && (bus.addr < `SND_FIX_END);
    assign bank_cs = bus.mreq && (bus.addr >= `SND_FIX_END) && (bus.addr < `SND_BANK_END);
    assign ram_cs  = bus.mreq && (bus.addr >= `SND_RAM_BASE);
    assign rom_cs  = (fix_cs || bank_cs) && bus.rd;

    // Port map on A7-A6
    assign tone_port = bus.iorq && (bus.addr[7:6] == 2'd0);
    assign ctl_port  = bus.iorq && (bus.addr[7:6] == 2'd1);
    assign pcm_port  = bus.iorq && (bus.addr[7:6] == 2'd2);

    assign rd_stb = bus.rd && (bus.mreq || bus.iorq);

    assign voice_wr.wr_tone = tone_port && bus.wr;
    assign voice_wr.wr_pcm  = pcm_port && bus.wr;
    assign voice_wr.reg_sel = bus.addr[0];
    assign voice_wr.data    = bus.dout;

    // Single low bit among bank[5:2] picks one of four ROM chips
    always_comb begin
        case (bank[5:2])
            4'b0111: onehot_idx = 2'd3;
            4'b1011: onehot_idx = 2'd2;
            4'b1101: onehot_idx = 2'd1;
            4'b1110: onehot_idx = 2'd0;
            default: onehot_idx = 2'd0;  // None or several low
        endcase
    end

    always_comb begin
        banked       = '0;
        banked[13:0] = bus.addr[13:0];
        case (board_kind)
            snd_pkg::bank_swap: begin
                banked[18:14] = {bank[3], bank[4], bank[2:0]};
            end
            snd_pkg::bank_onehot: begin
                banked[15:14] = bank[1:0];
                banked[17:16] = onehot_idx;
            end
            default: begin
                banked[17:14] = bank[3:0];
            end
        endcase
    end

    assign rom_addr = bank_cs ? banked + `SND_BANK_BASE : snd_pkg::rom_addr_t'(bus.addr);

    // Control latch, PCM held in reset until D6 is written high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank    <= '0;
            pcm_rst <= 1'b1;
        end else if (ctl_port && bus.wr) begin
            bank    <= bus.dout[5:0];
            pcm_rst <= ~bus.dout[6];
        end
    end

    always_ff @(posedge clk) begin
        if (ram_cs && bus.wr)
            ram[bus.addr[10:0]] <= bus.dout;
    end

    // Read data return
    always_ff @(posedge clk) begin
        if (rd_stb) begin
            if (rom_cs)
                cpu_din <= rom_data;
            else if (ram_cs)
                cpu_din <= ram[bus.addr[10:0]];
            else if (pcm_port)
                cpu_din <= {pcm_busy_n, 7'h7f};  // Busy flag only
            else
                cpu_din <= 8'hff;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            din_valid <= 1'b0;
        else
            din_valid <= rd_stb;
    end

endmodule

`default_nettype wire

// ==== hdl/snd_defs.svh ====
/* Board constants for the sound section.
   Gains are 4.4 fixed point, the pole is in sixteenths.
   Memory map bounds are CPU addresses; each window ends below the next bound. */
`ifndef SND_DEFS_SVH
`define SND_DEFS_SVH

// FM stand-in gain, 0.75 in 4.4
`define SND_TONE_GAIN 8'h0C

// One-pole filter coefficient, 10/16
`define SND_POLE_A 10

// Banked ROM starts at 64 KB into the sound ROM
`define SND_BANK_BASE 19'h10000

// End of the fixed program window
`define SND_FIX_END 16'h8000

// End of the banked window
`define SND_BANK_END 16'hE000

// Work RAM, 2 KB up to FFFF
`define SND_RAM_BASE 16'hF800

`endif

// ==== hdl/snd_mixer.sv ====
/* Two-channel mixer with 4.4 gains and 16-bit saturation.
   Voices change on the sample_cen edge, so the sum is taken one clock later.
   peak reflects only the most recent sample. */
`timescale 1ns/1ps
`default_nettype none

`include "snd_defs.svh"

module snd_mixer (
    input  wire              clk,
    input  wire              rst,
    input  wire              sample_cen,
    input  snd_pkg::sample_t tone,
    input  snd_pkg::sample_t pcm,
    input  wire [1:0]        fxlevel,
    input  wire              enable_tone,
    input  wire              enable_pcm,
    output snd_pkg::sample_t snd,
    output logic             sample,
    output logic             peak
);

    snd_pkg::gain_t     tone_gain;
    snd_pkg::gain_t     pcm_gain;
    logic signed [24:0] tone_w, pcm_w;
    logic signed [25:0] sum;
    logic signed [21:0] scaled;
    snd_pkg::sample_t   sat;
    logic               clip;
    logic               cen_d;

    always_comb begin
        case (fxlevel)
            2'd0:    pcm_gain = 8'h03;
            2'd1:    pcm_gain = 8'h06;
            2'd2:    pcm_gain = 8'h0C;
            default: pcm_gain = 8'h18;
        endcase
        if (!enable_pcm)
            pcm_gain = '0;
    end

    assign tone_gain = enable_tone ? `SND_TONE_GAIN : 8'h00;

    assign tone_w = tone * $signed({1'b0, tone_gain});
    assign pcm_w  = pcm * $signed({1'b0, pcm_gain});
    assign sum    = 26'(tone_w) + 26'(pcm_w);
    assign scaled = 22'(sum >>> 4);  // Drop the 4 fraction bits

    always_comb begin
        clip = 1'b1;
        if (scaled > 22'sd32767)
            sat = 16'sh7fff;
        else if (scaled < -22'sd32768)
            sat = 16'sh8000;
        else begin
            sat  = snd_pkg::sample_t'(scaled);
            clip = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_d  <= 1'b0;
            sample <= 1'b0;
            snd    <= '0;
            peak   <= 1'b0;
        end else begin
            cen_d  <= sample_cen;
            sample <= cen_d;
            if (cen_d) begin
                snd  <= sat;
                peak <= clip;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/snd_pcm_voice.sv ====
/* PCM voice fed one signed byte at a time by the CPU.
   busy_n drops on a write and rises at the next sample tick.
   pcm_rst is a synchronous clear of the latch and filter. */
`timescale 1ns/1ps
`default_nettype none

`include "snd_defs.svh"

module snd_pcm_voice (
    input  wire                clk,
    input  wire                rst,
    input  wire                pcm_rst,
    input  wire                sample_cen,
    input  snd_pkg::voice_wr_t voice_wr,
    output logic               busy_n,
    output snd_pkg::sample_t   pcm
);

    snd_pkg::cpu_data_t  latch;
    snd_pkg::sample_t    x_in;
    snd_pkg::sample_t    filt;
    logic signed [20:0]  acc;

    // Byte scaled to full 16-bit range
    assign x_in = snd_pkg::sample_t'({latch, 8'd0});

    // y = (a*y + (16-a)*x) / 16
    assign acc = 21'(`SND_POLE_A) * 21'(filt) + 21'(16 - `SND_POLE_A) * 21'(x_in);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_n <= 1'b1;
        end else if (pcm_rst) begin
            busy_n <= 1'b1;
        end else if (voice_wr.wr_pcm) begin
            busy_n <= 1'b0;  // Write wins over a tick in the same cycle
        end else if (sample_cen) begin
            busy_n <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            latch <= '0;
        end else if (pcm_rst) begin
            latch <= '0;
        end else if (voice_wr.wr_pcm) begin
            latch <= voice_wr.data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            filt <= '0;
        end else if (pcm_rst) begin
            filt <= '0;
        end else if (sample_cen) begin
            filt <= snd_pkg::sample_t'(acc >>> 4);
        end
    end

    assign pcm = filt;

endmodule

`default_nettype wire

// ==== hdl/snd_pkg.sv ====
/* Shared types for the sound section.
   Bus strobes are active high and last one clock. */
`default_nettype none

package snd_pkg;

    typedef logic        [15:0] cpu_addr_t;
    typedef logic        [7:0]  cpu_data_t;
    typedef logic        [18:0] rom_addr_t;   // Sound ROM byte address
    typedef logic signed [15:0] sample_t;
    typedef logic        [7:0]  gain_t;       // 4.4 fixed point
    typedef logic        [5:0]  bank_t;

    // Board wirings of the bank latch onto ROM address bits
    typedef enum logic [1:0] {
        bank_plain,
        bank_swap,
        bank_onehot
    } board_kind_t;

    // Sound CPU bus cycle, one clock per access
    typedef struct packed {
        cpu_addr_t addr;
        cpu_data_t dout;    // CPU write data
        logic      mreq;
        logic      iorq;
        logic      rd;
        logic      wr;
    } cpu_bus_t;

    // Register writes from the decoder to the voices
    typedef struct packed {
        logic      wr_tone;
        logic      wr_pcm;
        logic      reg_sel;  // Address bit 0
        cpu_data_t data;
    } voice_wr_t;

endpackage

`default_nettype wire

// ==== hdl/snd_tone_voice.sv ====
/* Square-wave voice standing in for the FM chip.
   Register 0 is the half period in sample ticks, 0 mutes the voice.
   Register 1 is the amplitude; output swings +/- amp*128. */
`timescale 1ns/1ps
`default_nettype none

module snd_tone_voice (
    input  wire                clk,
    input  wire                rst,
    input  wire                sample_cen,
    input  snd_pkg::voice_wr_t voice_wr,
    output snd_pkg::sample_t   tone
);

    snd_pkg::cpu_data_t period;
    snd_pkg::cpu_data_t amp;
    logic [7:0]         cnt;
    logic [7:0]         cnt_nx;
    logic               phase;
    logic               phase_nx;
    logic               wrap;
    snd_pkg::sample_t   level;

    assign cnt_nx   = cnt + 8'd1;
    assign wrap     = (cnt_nx == period);
    assign phase_nx = wrap ? ~phase : phase;
    assign level    = snd_pkg::sample_t'({1'b0, amp, 7'd0});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            period <= '0;
            amp    <= '0;
        end else if (voice_wr.wr_tone) begin
            if (voice_wr.reg_sel)
                amp <= voice_wr.data;
            else
                period <= voice_wr.data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            phase <= 1'b0;
            tone  <= '0;
        end else if (voice_wr.wr_tone && !voice_wr.reg_sel) begin
            cnt <= '0;  // New period restarts the count
        end else if (sample_cen) begin
            if (period == 8'd0) begin
                cnt  <= '0;
                tone <= '0;
            end else begin
                cnt   <= wrap ? 8'd0 : cnt_nx;
                phase <= phase_nx;
                tone  <= phase_nx ? -level : level;
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the sound board testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_snd_board -Mdir obj_dir
./obj_dir/Vtb_snd_board | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== tb/tb_snd_board.sv ====
/* Testbench for the sound board. The ROM is modeled as the low address byte
   XOR A5 and answers in the same cycle. Sample ticks are 4 cycles apart and a
   reference model of tone counter, filter and mixer predicts snd and peak. */
`timescale 1ns/1ps
`default_nettype none

`include "snd_defs.svh"

module tb_snd_board;

    typedef enum logic [2:0] {
        op_rom_rd, op_mem_rd, op_mem_wr, op_io_rd, op_io_wr, op_pcm_wr, op_tick, op_cfg
    } op_t;

    // cfg rows carry board_kind in addr and {enable_tone, enable_pcm, fxlevel} in data
    typedef struct packed {
        op_t         kind;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [31:0] exp;    // rom_addr, read data or expected peak
    } step_t;

    localparam logic [31:0] pk_any  = 32'd0;
    localparam logic [31:0] pk_high = 32'd1;
    localparam logic [31:0] pk_low  = 32'd2;
    localparam int          n_steps = 69;

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    snd_pkg::cpu_bus_t    bus;
    logic                 sample_cen;
    snd_pkg::board_kind_t board_kind;
    logic [1:0]           fxlevel;
    logic                 enable_tone;
    logic                 enable_pcm;
    snd_pkg::cpu_data_t   rom_data;
    snd_pkg::rom_addr_t   rom_addr;
    logic                 rom_cs;
    snd_pkg::cpu_data_t   cpu_din;
    logic                 din_valid;
    snd_pkg::sample_t     snd;
    logic                 sample;
    logic                 peak;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 0;
    logic [31:0] rng = 32'd61;

    // Reference model state
    int          m_period = 0;
    int          m_amp = 0;
    int          m_cnt = 0;
    int          m_tone = 0;
    int          m_filt = 0;
    int          m_snd = 0;
    logic        m_phase = 1'b0;
    logic        m_peak = 1'b0;
    logic        m_pcm_rst = 1'b1;
    logic [7:0]  m_latch = 8'h00;

    step_t steps [0:n_steps-1] = '{
        // PCM held in reset ignores a sample write
        '{op_cfg, 16'h0000, 8'h00, 32'h0}, '{op_io_wr, 16'h0080, 8'h11, 32'h0},
        '{op_io_rd, 16'h0080, 8'h00, 32'hff},
        // Plain bank wiring with bank 05 and PCM released
        '{op_io_wr, 16'h0040, 8'h45, 32'h0}, '{op_rom_rd, 16'h1234, 8'h00, 32'h01234},
        '{op_rom_rd, 16'h8123, 8'h00, 32'h24123}, '{op_rom_rd, 16'hdfff, 8'h00, 32'h25fff},
        // Swapped wiring
        '{op_cfg, 16'h0001, 8'h00, 32'h0}, '{op_io_wr, 16'h0040, 8'h5b, 32'h0},
        '{op_rom_rd, 16'h80f0, 8'h00, 32'h7c0f0}, '{op_io_wr, 16'h0040, 8'h48, 32'h0},
        '{op_rom_rd, 16'ha000, 8'h00, 32'h52000},
        // One-hot chip select with one, none and several bits low
        '{op_cfg, 16'h0002, 8'h00, 32'h0}, '{op_io_wr, 16'h0040, 8'h77, 32'h0},
        '{op_rom_rd, 16'h8010, 8'h00, 32'h2c010}, '{op_io_wr, 16'h0040, 8'h7c, 32'h0},
        '{op_rom_rd, 16'hc000, 8'h00, 32'h10000}, '{op_io_wr, 16'h0040, 8'h43, 32'h0},
        '{op_rom_rd, 16'hbffe, 8'h00, 32'h1fffe},
        // Work RAM, unmapped memory and port 3
        '{op_mem_wr, 16'hf800, 8'h3c, 32'h0}, '{op_mem_wr, 16'hffff, 8'hc3, 32'h0},
        '{op_mem_rd, 16'hf800, 8'h00, 32'h3c}, '{op_mem_rd, 16'hffff, 8'h00, 32'hc3},
        '{op_mem_rd, 16'he000, 8'h00, 32'hff}, '{op_io_rd, 16'h00c0, 8'h00, 32'hff},
        // busy_n drops on a write and rises at the next tick
        '{op_pcm_wr, 16'h0080, 8'h00, 32'h0}, '{op_io_rd, 16'h0080, 8'h00, 32'h7f},
        '{op_tick, 16'h0000, 8'h00, pk_any}, '{op_io_rd, 16'h0080, 8'h00, 32'hff},
        // Tone alone with period 3
        '{op_cfg, 16'h0000, 8'h08, 32'h0}, '{op_io_wr, 16'h0001, 8'h20, 32'h0},
        '{op_io_wr, 16'h0000, 8'h03, 32'h0}, '{op_tick, 16'h0000, 8'h00, pk_low},
        '{op_tick, 16'h0000, 8'h00, pk_low}, '{op_tick, 16'h0000, 8'h00, pk_low},
        '{op_tick, 16'h0000, 8'h00, pk_low}, '{op_tick, 16'h0000, 8'h00, pk_low},
        '{op_tick, 16'h0000, 8'h00, pk_low}, '{op_io_wr, 16'h0000, 8'h00, 32'h0},
        // PCM alone at each fxlevel
        '{op_cfg, 16'h0000, 8'h04, 32'h0}, '{op_pcm_wr, 16'h0080, 8'h00, 32'h0},
        '{op_tick, 16'h0000, 8'h00, pk_any}, '{op_cfg, 16'h0000, 8'h05, 32'h0},
        '{op_pcm_wr, 16'h0080, 8'h00, 32'h0}, '{op_tick, 16'h0000, 8'h00, pk_any},
        '{op_cfg, 16'h0000, 8'h06, 32'h0}, '{op_pcm_wr, 16'h0080, 8'h00, 32'h0},
        '{op_tick, 16'h0000, 8'h00, pk_any}, '{op_cfg, 16'h0000, 8'h07, 32'h0},
        '{op_pcm_wr, 16'h0080, 8'h00, 32'h0}, '{op_tick, 16'h0000, 8'h00, pk_any},
        // Loud tone plus full-scale PCM saturates high
        '{op_cfg, 16'h0000, 8'h0f, 32'h0}, '{op_io_wr, 16'h0001, 8'h7f, 32'h0},
        '{op_io_wr, 16'h0000, 8'hff, 32'h0}, '{op_io_wr, 16'h0080, 8'h7f, 32'h0},
        '{op_tick, 16'h0000, 8'h00, pk_any}, '{op_tick, 16'h0000, 8'h00, pk_any},
        '{op_tick, 16'h0000, 8'h00, pk_any}, '{op_tick, 16'h0000, 8'h00, pk_high},
        '{op_tick, 16'h0000, 8'h00, pk_high},
        // Quiet sample clears peak before negative full scale
        '{op_io_wr, 16'h0001, 8'h00, 32'h0}, '{op_io_wr, 16'h0080, 8'h00, 32'h0},
        '{op_tick, 16'h0000, 8'h00, pk_low}, '{op_io_wr, 16'h0080, 8'h80, 32'h0},
        '{op_tick, 16'h0000, 8'h00, pk_any}, '{op_tick, 16'h0000, 8'h00, pk_any},
        '{op_tick, 16'h0000, 8'h00, pk_any}, '{op_tick, 16'h0000, 8'h00, pk_high},
        '{op_tick, 16'h0000, 8'h00, pk_high}
    };

    snd_board i_dut (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus),
        .sample_cen  (sample_cen),
        .board_kind  (board_kind),
        .fxlevel     (fxlevel),
        .enable_tone (enable_tone),
        .enable_pcm  (enable_pcm),
        .rom_data    (rom_data),
        .rom_addr    (rom_addr),
        .rom_cs      (rom_cs),
        .cpu_din     (cpu_din),
        .din_valid   (din_valid),
        .snd         (snd),
        .sample      (sample),
        .peak        (peak)
    );

    always #50 clk = ~clk;

    function automatic snd_pkg::cpu_data_t rom_byte(input snd_pkg::rom_addr_t a);
        return a[7:0] ^ 8'ha5;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    assign rom_data = rom_byte(rom_addr);  // Same-cycle ROM

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("checks=%0d errors=%0d", checks, errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic step_clk();
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic model_io_write(input logic [15:0] addr, input logic [7:0] data);
        case (addr[7:6])
            2'd0: begin
                if (addr[0]) begin
                    m_amp = int'(data);
                end else begin
                    m_period = int'(data);
                    m_cnt    = 0;
                end
            end
            2'd1: begin
                m_pcm_rst = ~data[6];
                if (m_pcm_rst) begin
                    m_latch = 8'h00;
                    m_filt  = 0;
                end
            end
            2'd2: if (!m_pcm_rst) m_latch = data;
            default: ;
        endcase
    endtask

    task automatic model_tick();
        int tone_gain;
        int pcm_gain;
        int sum;
        if (m_period == 0) begin
            m_cnt  = 0;
            m_tone = 0;
        end else begin
            m_cnt = m_cnt + 1;
            if (m_cnt == m_period) begin
                m_cnt   = 0;
                m_phase = ~m_phase;
            end
            m_tone = m_phase ? -(m_amp * 128) : m_amp * 128;
        end
        if (!m_pcm_rst)
            m_filt = (`SND_POLE_A * m_filt
                      + (16 - `SND_POLE_A) * int'($signed(m_latch)) * 256) >>> 4;
        tone_gain = enable_tone ? int'(`SND_TONE_GAIN) : 0;
        case (fxlevel)
            2'd0:    pcm_gain = 3;
            2'd1:    pcm_gain = 6;
            2'd2:    pcm_gain = 12;
            default: pcm_gain = 24;
        endcase
        if (!enable_pcm)
            pcm_gain = 0;
        sum    = (m_tone * tone_gain + m_filt * pcm_gain) >>> 4;
        m_peak = (sum > 32767) || (sum < -32768);
        if (sum > 32767)
            m_snd = 32767;
        else if (sum < -32768)
            m_snd = -32768;
        else
            m_snd = sum;
    endtask

    task automatic run_step(input step_t s);
        logic [7:0] wr_byte;
        case (s.kind)
            op_cfg: begin
                board_kind  = snd_pkg::board_kind_t'(s.addr[1:0]);
                enable_tone = s.data[3];
                enable_pcm  = s.data[2];
                fxlevel     = s.data[1:0];
            end
            op_rom_rd, op_mem_rd, op_io_rd: begin
                bus.addr = s.addr;
                bus.mreq = (s.kind != op_io_rd);
                bus.iorq = (s.kind == op_io_rd);
                bus.rd   = 1'b1;
                #5;
                check_value("rom_cs", 32'(rom_cs), 32'(s.kind == op_rom_rd));
                if (s.kind == op_rom_rd)
                    check_value("rom_addr", 32'(rom_addr), s.exp);
                step_clk();
                bus = '0;
                while (!din_valid)
                    step_clk();
                if (s.kind == op_rom_rd)
                    check_value("cpu_din", 32'(cpu_din), 32'(rom_byte(s.exp[18:0])));
                else
                    check_value("cpu_din", 32'(cpu_din), s.exp);
            end
            op_tick: begin
                sample_cen = 1'b1;
                step_clk();
                sample_cen = 1'b0;
                model_tick();
                while (!sample)
                    step_clk();
                check_value("snd", 32'(snd), 32'(m_snd));
                check_value("peak", 32'(peak), 32'(m_peak));
                if (s.exp != pk_any)
                    check_value("peak", 32'(peak), 32'(s.exp == pk_high));
                repeat (2) step_clk();  // Keeps ticks 4 cycles apart
            end
            default: begin
                wr_byte = s.data;
                if (s.kind == op_pcm_wr) begin
                    rng     = lcg_next(rng);
                    wr_byte = rng[23:16];
                end
                bus.addr = s.addr;
                bus.dout = wr_byte;
                bus.mreq = (s.kind == op_mem_wr);
                bus.iorq = (s.kind != op_mem_wr);
                bus.wr   = 1'b1;
                step_clk();
                bus = '0;
                if (s.kind != op_mem_wr)
                    model_io_write(s.addr, wr_byte);
            end
        endcase
    endtask

    initial begin
        bus         = '0;
        sample_cen  = 1'b0;
        board_kind  = snd_pkg::bank_plain;
        fxlevel     = 2'd0;
        enable_tone = 1'b0;
        enable_pcm  = 1'b0;
        limit       = n_steps * 8 + 100;
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;
        check_value("din_valid", 32'(din_valid), 32'd0);
        check_value("sample", 32'(sample), 32'd0);
        check_value("peak", 32'(peak), 32'd0);
        check_value("snd", 32'(snd), 32'd0);
        for (int i = 0; i < n_steps; i++)
            run_step(steps[i]);
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/snd_pkg.sv
hdl/snd_bus_decode.sv
hdl/snd_tone_voice.sv
hdl/snd_pcm_voice.sv
hdl/snd_mixer.sv
hdl/snd_board.sv
tb/tb_snd_board.sv
